// ==== datapath_params.svh ====
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// Bus and register sizing
`define WORD_WIDTH 32
`define REG_COUNT  16

// ALU operation select, 5 bits wide
`define ALU_ADD  5'b00011
`define ALU_SUB  5'b00100
`define ALU_AND  5'b00101
`define ALU_OR   5'b00110
`define ALU_SHR  5'b00111
`define ALU_SHRA 5'b01000
`define ALU_SHL  5'b01001
`define ALU_ROR  5'b01010
`define ALU_ROL  5'b01011
`define ALU_NOP  5'b01101 // Idle code, result stays zero
`define ALU_MUL  5'b01111 // Full signed product
`define ALU_DIV  5'b10000 // Quotient low, remainder high
`define ALU_NEG  5'b10001
`define ALU_NOT  5'b10010

// Z register halves
`define Z_LOW_MSB  (`WORD_WIDTH - 1)
`define Z_HIGH_LSB `WORD_WIDTH

`endif

// ==== datapathPkg.sv ====
`include "datapath_params.svh"

package datapathPkg;

    // One word on the shared bus
    typedef logic [`WORD_WIDTH-1:0] word_t;

    // Double word for the ALU result and Z
    typedef logic [2*`WORD_WIDTH-1:0] wideWord_t;

    // Operation select
    typedef logic [4:0] aluOp_t;

    // One bit per general register, one-hot in normal use
    typedef logic [`REG_COUNT-1:0] regMask_t;

endpackage

// ==== registerFile.sv ====
`timescale 1ns/1ps
`include "datapath_params.svh"

module registerFile
    import datapathPkg::*;
(
    input  logic     clock,
    input  logic     rstN,
    input  regMask_t regIn,                   // Load strobes, bit i loads Ri
    input  word_t    busData,
    output word_t    regValues [`REG_COUNT]   // Read by the bus mux
);

    word_t regStore [`REG_COUNT];

    // One register per strobe bit
    // Several bits may be set, then all of them take the same bus word
    genvar regIdx;
    generate
        for (regIdx = 0; regIdx < `REG_COUNT; regIdx++) begin : genReg
            always_ff @(posedge clock) begin
                if (!rstN) begin
                    regStore[regIdx] <= '0;
                end else if (regIn[regIdx]) begin
                    regStore[regIdx] <= busData; // Sampled at the end of the cycle
                end
            end

            assign regValues[regIdx] = regStore[regIdx];
        end
    endgenerate

endmodule

// ==== specialRegisters.sv ====
`timescale 1ns/1ps
`include "datapath_params.svh"

module specialRegisters
    import datapathPkg::*;
(
    input  logic      clock,
    input  logic      rstN,
    input  logic      hiIn,
    input  logic      loIn,
    input  logic      pcIn,
    input  logic      irIn,
    input  logic      marIn,
    input  logic      mdrIn,
    input  logic      yIn,
    input  logic      zIn,
    input  logic      read,       // MDR source is memory when high
    input  word_t     busData,
    input  word_t     memData,
    input  wideWord_t aluResult,
    output word_t     hiValue,
    output word_t     loValue,
    output word_t     pcValue,
    output word_t     mdrValue,
    output word_t     yValue,
    output word_t     memAddress, // MAR contents
    output word_t     instruction, // IR contents
    output wideWord_t zValue
);

    word_t     hiReg;
    word_t     loReg;
    word_t     pcReg;
    word_t     irReg;
    word_t     marReg;
    word_t     mdrReg;
    word_t     yReg;
    wideWord_t zReg;
    word_t     mdrNext;

    // MDR input select
    assign mdrNext = read ? memData : busData;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            hiReg  <= '0;
            loReg  <= '0;
            pcReg  <= '0;
            irReg  <= '0;
            marReg <= '0;
            mdrReg <= '0;
            yReg   <= '0;
            zReg   <= '0;
        end else begin
            if (hiIn) begin
                hiReg <= busData;
            end
            if (loIn) begin
                loReg <= busData;
            end
            if (pcIn) begin
                pcReg <= busData; // Usually Z low after an increment
            end
            if (irIn) begin
                irReg <= busData;
            end
            if (marIn) begin
                marReg <= busData;
            end
            if (mdrIn) begin
                mdrReg <= mdrNext;
            end
            if (yIn) begin
                yReg <= busData; // A operand for the next ALU step
            end
            if (zIn) begin
                zReg <= aluResult; // Both halves at once
            end
        end
    end

    assign hiValue     = hiReg;
    assign loValue     = loReg;
    assign pcValue     = pcReg;
    assign mdrValue    = mdrReg;
    assign yValue      = yReg;
    assign memAddress  = marReg;
    assign instruction = irReg;
    assign zValue      = zReg;

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps
`include "datapath_params.svh"

module alu
    import datapathPkg::*;
(
    input  word_t     aOperand, // From Y
    input  word_t     bOperand, // From the bus
    input  aluOp_t    aluOp,
    input  logic      incPc,    // Forces B plus one
    output wideWord_t result
);

    logic [4:0]                      shiftCount;
    word_t                           rotRight;
    word_t                           rotLeft;
    logic signed [2*`WORD_WIDTH-1:0] aWide;
    logic signed [2*`WORD_WIDTH-1:0] bWide;
    wideWord_t                       product;
    word_t                           quotient;
    word_t                           remainder;

    // Single word results go out zero extended
    function automatic wideWord_t widen(word_t value);
        return {{`WORD_WIDTH{1'b0}}, value};
    endfunction

    assign shiftCount = bOperand[4:0];

    // A count of zero shifts the wrap part fully out
    assign rotRight = (aOperand >> shiftCount) | (aOperand << (`WORD_WIDTH - shiftCount));
    assign rotLeft  = (aOperand << shiftCount) | (aOperand >> (`WORD_WIDTH - shiftCount));

    // Signed multiply on sign extended operands, low 64 bits are exact
    assign aWide   = {{`WORD_WIDTH{aOperand[`WORD_WIDTH-1]}}, aOperand};
    assign bWide   = {{`WORD_WIDTH{bOperand[`WORD_WIDTH-1]}}, bOperand};
    assign product = aWide * bWide;

    always_comb begin
        if (bOperand == '0) begin
            // Divide by zero convention
            quotient  = '1;
            remainder = aOperand;
        end else if (bOperand == '1) begin
            // Minus one handled apart, the most negative dividend would overflow
            quotient  = -aOperand;
            remainder = '0;
        end else begin
            quotient  = word_t'($signed(aOperand) / $signed(bOperand));
            remainder = word_t'($signed(aOperand) % $signed(bOperand)); // Sign of dividend
        end
    end

    always_comb begin
        result = '0;
        if (incPc) begin
            result = widen(bOperand + 1'b1); // PC increment during fetch
        end else begin
            case (aluOp)
                `ALU_ADD: begin
                    result = widen(aOperand + bOperand);
                end
                `ALU_SUB: begin
                    result = widen(aOperand - bOperand);
                end
                `ALU_AND: begin
                    result = widen(aOperand & bOperand);
                end
                `ALU_OR: begin
                    result = widen(aOperand | bOperand);
                end
                `ALU_SHR: begin
                    result = widen(aOperand >> shiftCount);
                end
                `ALU_SHRA: begin
                    result = widen(word_t'($signed(aOperand) >>> shiftCount));
                end
                `ALU_SHL: begin
                    result = widen(aOperand << shiftCount);
                end
                `ALU_ROR: begin
                    result = widen(rotRight);
                end
                `ALU_ROL: begin
                    result = widen(rotLeft);
                end
                `ALU_NEG: begin
                    result = widen(-bOperand); // B only
                end
                `ALU_NOT: begin
                    result = widen(~bOperand);
                end
                `ALU_MUL: begin
                    result = product;
                end
                `ALU_DIV: begin
                    result = {remainder, quotient};
                end
                `ALU_NOP: begin
                    result = '0;
                end
                default: begin
                    result = '0;
                end
            endcase
        end
    end

endmodule

// ==== busMux.sv ====
`timescale 1ns/1ps
`include "datapath_params.svh"

module busMux
    import datapathPkg::*;
(
    input  regMask_t  regOut,
    input  word_t     regValues [`REG_COUNT],
    input  logic      hiOut,
    input  logic      loOut,
    input  logic      pcOut,
    input  logic      mdrOut,
    input  logic      zHighOut,
    input  logic      zLowOut,
    input  word_t     hiValue,
    input  word_t     loValue,
    input  word_t     pcValue,
    input  word_t     mdrValue,
    input  wideWord_t zValue,
    output word_t     busData
);

    // Source numbers past the general registers
    localparam int         SOURCE_COUNT = `REG_COUNT + 6;
    localparam logic [4:0] SEL_HI       = 5'(`REG_COUNT);
    localparam logic [4:0] SEL_LO       = 5'(`REG_COUNT + 1);
    localparam logic [4:0] SEL_PC       = 5'(`REG_COUNT + 2);
    localparam logic [4:0] SEL_MDR      = 5'(`REG_COUNT + 3);
    localparam logic [4:0] SEL_ZHIGH    = 5'(`REG_COUNT + 4);
    localparam logic [4:0] SEL_ZLOW     = 5'(`REG_COUNT + 5);

    logic [SOURCE_COUNT-1:0] request;
    logic [4:0]              sourceSel;
    logic                    sourceValid;

    // Bit 0 is R0, the highest priority
    assign request = {zLowOut, zHighOut, mdrOut, pcOut, loOut, hiOut, regOut};

    // Scan down so the lowest set bit is the one left standing
    always_comb begin
        sourceSel   = '0;
        sourceValid = 1'b0;
        for (int i = SOURCE_COUNT - 1; i >= 0; i--) begin
            if (request[i]) begin
                sourceSel   = 5'(i);
                sourceValid = 1'b1;
            end
        end
    end

    always_comb begin
        busData = '0; // Idle bus reads zero
        if (sourceValid) begin
            if (sourceSel < SEL_HI) begin
                busData = regValues[sourceSel[3:0]];
            end else begin
                case (sourceSel)
                    SEL_HI:    busData = hiValue;
                    SEL_LO:    busData = loValue;
                    SEL_PC:    busData = pcValue;
                    SEL_MDR:   busData = mdrValue;
                    SEL_ZHIGH: busData = zValue[2*`WORD_WIDTH-1:`Z_HIGH_LSB];
                    SEL_ZLOW:  busData = zValue[`Z_LOW_MSB:0];
                    default:   busData = '0;
                endcase
            end
        end
    end

endmodule

// ==== datapath.sv ====
`timescale 1ns/1ps
`include "datapath_params.svh"

module datapath
    import datapathPkg::*;
(
    input  logic     clock,
    input  logic     rstN,
    input  regMask_t regIn,
    input  regMask_t regOut,
    input  logic     hiIn,
    input  logic     hiOut,
    input  logic     loIn,
    input  logic     loOut,
    input  logic     pcIn,
    input  logic     pcOut,
    input  logic     irIn,
    input  logic     marIn,
    input  logic     mdrIn,
    input  logic     mdrOut,
    input  logic     yIn,
    input  logic     zIn,
    input  logic     zHighOut,
    input  logic     zLowOut,
    input  logic     incPc,
    input  logic     read,
    input  word_t    memData,    // Memory read data into MDR
    input  aluOp_t   aluOp,
    output word_t    busData,
    output word_t    memAddress,
    output word_t    instruction
);

    word_t     regValues [`REG_COUNT];
    word_t     hiValue;
    word_t     loValue;
    word_t     pcValue;
    word_t     mdrValue;
    word_t     yValue;
    wideWord_t zValue;
    wideWord_t aluResult;

    // R0 to R15
    registerFile uRegisterFile (
        .clock    (clock),
        .rstN     (rstN),
        .regIn    (regIn),
        .busData  (busData),
        .regValues(regValues)
    );

    specialRegisters uSpecialRegisters (
        .clock      (clock),
        .rstN       (rstN),
        .hiIn       (hiIn),
        .loIn       (loIn),
        .pcIn       (pcIn),
        .irIn       (irIn),
        .marIn      (marIn),
        .mdrIn      (mdrIn),
        .yIn        (yIn),
        .zIn        (zIn),
        .read       (read),
        .busData    (busData),
        .memData    (memData),
        .aluResult  (aluResult),
        .hiValue    (hiValue),
        .loValue    (loValue),
        .pcValue    (pcValue),
        .mdrValue   (mdrValue),
        .yValue     (yValue),
        .memAddress (memAddress),
        .instruction(instruction),
        .zValue     (zValue)
    );

    // A from Y, B straight off the bus
    alu uAlu (
        .aOperand(yValue),
        .bOperand(busData),
        .aluOp   (aluOp),
        .incPc   (incPc),
        .result  (aluResult)
    );

    busMux uBusMux (
        .regOut   (regOut),
        .regValues(regValues),
        .hiOut    (hiOut),
        .loOut    (loOut),
        .pcOut    (pcOut),
        .mdrOut   (mdrOut),
        .zHighOut (zHighOut),
        .zLowOut  (zLowOut),
        .hiValue  (hiValue),
        .loValue  (loValue),
        .pcValue  (pcValue),
        .mdrValue (mdrValue),
        .zValue   (zValue),
        .busData  (busData)
    );

endmodule

// ==== datapath_assertions.sv ====
`timescale 1ns/1ps
`include "datapath_params.svh"

module datapathChecker
    import datapathPkg::*;
(
    input logic     clock,
    input logic     rstN,
    input regMask_t regIn,
    input regMask_t regOut,
    input logic     hiIn,
    input logic     hiOut,
    input logic     loIn,
    input logic     loOut,
    input logic     pcIn,
    input logic     pcOut,
    input logic     irIn,
    input logic     marIn,
    input logic     mdrIn,
    input logic     mdrOut,
    input logic     yIn,
    input logic     zIn,
    input logic     zHighOut,
    input logic     zLowOut,
    input logic     incPc,
    input logic     read,
    input word_t    memData,
    input aluOp_t   aluOp,
    input word_t    busData,
    input word_t    memAddress,
    input word_t    instruction
);

    int        errorCount = 0;
    word_t     gpr [`REG_COUNT];
    word_t     hi, lo, pc, ir, mar, mdr, y;
    wideWord_t z;
    word_t     expBus;

    // Expected result straight from the instruction set rules
    function automatic wideWord_t refAlu(word_t a, word_t b, aluOp_t op, logic inc);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        twice;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        twice = {a, a};
        if (inc) return {32'h0, b + 32'h1};
        case (op)
            `ALU_ADD:  return {32'h0, a + b};
            `ALU_SUB:  return {32'h0, a - b};
            `ALU_AND:  return {32'h0, a & b};
            `ALU_OR:   return {32'h0, a | b};
            `ALU_SHR:  return {32'h0, a >> b[4:0]};
            `ALU_SHRA: return {32'h0, 32'(sa >>> b[4:0])};
            `ALU_SHL:  return {32'h0, a << b[4:0]};
            `ALU_ROR:  return {32'h0, 32'(twice >> b[4:0])};
            `ALU_ROL:  return {32'h0, 32'((twice << b[4:0]) >> 32)};
            `ALU_NEG:  return {32'h0, 32'h0 - b};
            `ALU_NOT:  return {32'h0, ~b};
            `ALU_MUL:  return 64'(sa * sb);
            `ALU_DIV:  return (b == 0) ? {a, 32'hffffffff} : {32'(sa % sb), 32'(sa / sb)};
            default:   return 64'h0;
        endcase
    endfunction

    // Later assignments win, so the highest priority source comes last
    always_comb begin
        expBus = '0;
        if (zLowOut)  expBus = z[31:0];
        if (zHighOut) expBus = z[63:32];
        if (mdrOut)   expBus = mdr;
        if (pcOut)    expBus = pc;
        if (loOut)    expBus = lo;
        if (hiOut)    expBus = hi;
        for (int i = `REG_COUNT - 1; i >= 0; i--) begin
            if (regOut[i]) expBus = gpr[i];
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) gpr[i] <= '0;
            {hi, lo, pc, ir, mar, mdr, y} <= '0;
            z <= '0;
        end else begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                if (regIn[i]) gpr[i] <= expBus;
            end
            if (hiIn)  hi  <= expBus;
            if (loIn)  lo  <= expBus;
            if (pcIn)  pc  <= expBus;
            if (irIn)  ir  <= expBus;
            if (marIn) mar <= expBus;
            if (mdrIn) mdr <= read ? memData : expBus;
            if (yIn)   y   <= expBus;
            if (zIn)   z   <= refAlu(y, expBus, aluOp, incPc);
        end
    end

    busMatch: assert property (@(posedge clock) disable iff (!rstN) busData == expBus)
        else begin
            $error("CHECK FAILED busData expected %h actual %h",
                   $sampled(expBus), $sampled(busData));
            errorCount = errorCount + 1;
        end

    marMatch: assert property (@(posedge clock) disable iff (!rstN) memAddress == mar)
        else begin
            $error("CHECK FAILED memAddress expected %h actual %h",
                   $sampled(mar), $sampled(memAddress));
            errorCount = errorCount + 1;
        end

    irMatch: assert property (@(posedge clock) disable iff (!rstN) instruction == ir)
        else begin
            $error("CHECK FAILED instruction expected %h actual %h",
                   $sampled(ir), $sampled(instruction));
            errorCount = errorCount + 1;
        end

endmodule

bind datapath datapathChecker uChecker (.*);

// ==== datapathTb.sv ====
`timescale 1ns/1ps
`include "datapath_params.svh"

module datapathTb;
    import datapathPkg::*;

    localparam int EDGE_TIMEOUT = 50; // Polls of 1 ns per falling edge

    logic     clock = 1'b0;
    logic     rstN;
    regMask_t regIn, regOut;
    logic     hiIn, hiOut, loIn, loOut, pcIn, pcOut, irIn, marIn;
    logic     mdrIn, mdrOut, yIn, zIn, zHighOut, zLowOut, incPc, read;
    word_t    memData, busData, memAddress, instruction;
    aluOp_t   aluOp;
    int       fallCount = 0;
    logic [31:0] rngState = 32'd53464;

    datapath UUT (.*);

    initial begin
        forever #5 clock = ~clock;
    end

    always @(negedge clock) fallCount = fallCount + 1;

    // Stop at the first assertion failure
    always @(UUT.uChecker.errorCount) begin
        if (UUT.uChecker.errorCount != 0) begin
            $display("Finished with errors");
            $fatal(1, "assertion failure in the datapath checker");
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    task automatic clearStrobes();
        {regIn, regOut, hiIn, hiOut, loIn, loOut, pcIn, pcOut, irIn, marIn} = '0;
        {mdrIn, mdrOut, yIn, zIn, zHighOut, zLowOut, incPc, read} = '0;
        aluOp = `ALU_NOP;
    endtask

    // Ends one micro-step, new strobes go on at the falling edge
    task automatic waitFall();
        int start;
        int polls;
        start = fallCount;
        polls = 0;
        while (fallCount == start) begin
            if (polls == EDGE_TIMEOUT) begin
                $display("Timed out waiting for a falling clock edge");
                $display("Finished with errors");
                $fatal(1, "clock stopped");
            end
            #1;
            polls++;
        end
        clearStrobes();
    endtask

    task automatic loadWord(word_t value, regMask_t mask, logic toHi, logic toLo);
        memData = value;
        read = 1'b1;
        mdrIn = 1'b1;
        waitFall();
        mdrOut = 1'b1;
        regIn = mask;
        hiIn = toHi;
        loIn = toLo;
        waitFall();
    endtask

    task automatic runAlu(aluOp_t op, int aReg, int bReg);
        regOut[aReg] = 1'b1;
        yIn = 1'b1;
        waitFall();
        regOut[bReg] = 1'b1;
        aluOp = op;
        zIn = 1'b1;
        waitFall();
        zLowOut = 1'b1; // Low half into LO, then high half into HI
        loIn = 1'b1;
        waitFall();
        zHighOut = 1'b1;
        hiIn = 1'b1;
        waitFall();
        loOut = 1'b1;
        waitFall();
        hiOut = 1'b1;
        waitFall();
    endtask

    initial begin
        aluOp_t ops [14] = '{`ALU_ADD, `ALU_SUB, `ALU_AND, `ALU_OR, `ALU_SHR, `ALU_SHRA,
                             `ALU_SHL, `ALU_ROR, `ALU_ROL, `ALU_NEG, `ALU_NOT, `ALU_MUL,
                             `ALU_DIV, `ALU_NOP};
        clearStrobes();
        memData = '0;
        rstN = 1'b0;
        waitFall();
        waitFall();
        rstN = 1'b1;

        // Every source reads zero after reset
        for (int i = 0; i < `REG_COUNT; i++) begin
            regOut[i] = 1'b1;
            waitFall();
        end
        for (int i = 0; i < 6; i++) begin
            {hiOut, loOut, pcOut, mdrOut, zHighOut, zLowOut} = 6'b100000 >> i;
            waitFall();
        end

        for (int i = 0; i < `REG_COUNT; i++) loadWord(nextRandom(), regMask_t'(1) << i, 0, 0);
        loadWord(nextRandom(), 16'h0000, 1, 1);
        loadWord(nextRandom(), 16'hf0f0, 0, 1); // Several loads in one cycle
        for (int i = 0; i < `REG_COUNT; i++) begin
            regOut[i] = 1'b1;
            waitFall();
        end
        hiOut = 1'b1;
        waitFall();
        loOut = 1'b1;
        waitFall();

        for (int k = 0; k < 4; k++) begin
            foreach (ops[j]) begin
                loadWord(nextRandom(), 16'h0002, 0, 0);
                loadWord(nextRandom(), 16'h0004, 0, 0);
                runAlu(ops[j], 1, 2);
            end
        end
        loadWord(32'h1, 16'h0004, 0, 0);
        runAlu(`ALU_NEG, 1, 2);
        loadWord(32'h0, 16'h0004, 0, 0);
        runAlu(`ALU_DIV, 1, 2); // Division by zero

        // Instruction fetch
        loadWord(nextRandom(), 16'h0020, 0, 0);
        regOut[5] = 1'b1;
        pcIn = 1'b1;
        waitFall();
        pcOut = 1'b1;
        marIn = 1'b1;
        incPc = 1'b1;
        zIn = 1'b1;
        waitFall();
        zLowOut = 1'b1;
        pcIn = 1'b1;
        read = 1'b1;
        mdrIn = 1'b1;
        memData = nextRandom();
        waitFall();
        mdrOut = 1'b1;
        irIn = 1'b1;
        waitFall();
        pcOut = 1'b1;
        waitFall();

        // Two drivers at once
        regOut[3] = 1'b1;
        hiOut = 1'b1;
        waitFall();
        loOut = 1'b1;
        zLowOut = 1'b1;
        waitFall();
        pcOut = 1'b1;
        mdrOut = 1'b1;
        waitFall();
        waitFall();

        if (UUT.uChecker.errorCount == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "checker reported mismatches");
        end
    end

endmodule

// ==== files.f ====
+incdir+.
datapathPkg.sv
registerFile.sv
specialRegisters.sv
alu.sv
busMux.sv
datapath.sv
datapath_assertions.sv
datapathTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f files.f --top-module datapathTb -o simv \
    && ./obj_dir/simv +verilator+error+limit+100 | grep -q "Finished with no errors" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
